// ==== common/cpu_pkg.sv ====
package cpu_pkg;

    //////////////////////////////////////////////////////////////////////
    // ALU operations
    //////////////////////////////////////////////////////////////////////

    // Decoded by the front end, carried into execute
    // 3 bits so every code is a defined operation
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,     // a + b
        ALU_SUB = 3'd1,     // a - b, also used for branch compare
        ALU_AND = 3'd2,     // Bitwise and
        ALU_OR  = 3'd3,     // Bitwise or
        ALU_XOR = 3'd4,     // Bitwise xor
        ALU_SLT = 3'd5,     // Signed a < b, gives 1 or 0
        ALU_SLL = 3'd6,     // Shift left logical by b[4:0]
        ALU_SRL = 3'd7      // Shift right logical by b[4:0]
    } alu_op_e;

    // Branches are SUB plus the zero flag
    // Loads and stores form their address with ADD

endpackage

// ==== common/ex_mem_if.sv ====
`timescale 1ns/1ps

interface ex_mem_if #(
    parameter int WORD_SIZE = 32,
    parameter int REG_SEL   = 5,
    parameter int ADDR_SIZE = 10
);

    // Data fields
    logic [ADDR_SIZE-1:0] branch_target;    // pc + imm
    logic [WORD_SIZE-1:0] alu_result;       // ALU output, also memory address
    logic [WORD_SIZE-1:0] write_data;       // Store data from rs2
    logic [REG_SEL-1:0]   rd;               // Destination register

    // Control fields, all low means bubble
    logic alu_zero;
    logic branch;
    logic jump;
    logic mem_read;
    logic mem_write;
    logic reg_write;

    modport producer (
        output branch_target, alu_result, write_data, rd,
        output alu_zero, branch, jump, mem_read, mem_write, reg_write
    );

    modport consumer (
        input branch_target, alu_result, write_data, rd,
        input alu_zero, branch, jump, mem_read, mem_write, reg_write
    );

endinterface

// ==== execute/alu.sv ====
`timescale 1ns/1ps

module alu #(
    parameter int WORD_SIZE = 32
) (
    input  logic                 clk,       // Assertion sampling only
    input  logic                 rst,
    input  cpu_pkg::alu_op_e     op,
    input  logic [WORD_SIZE-1:0] a,
    input  logic [WORD_SIZE-1:0] b,
    output logic [WORD_SIZE-1:0] result,
    output logic                 zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Shift amount from low bits of b

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD: result = a + b;
            cpu_pkg::ALU_SUB: result = a - b;
            cpu_pkg::ALU_AND: result = a & b;
            cpu_pkg::ALU_OR:  result = a | b;
            cpu_pkg::ALU_XOR: result = a ^ b;
            cpu_pkg::ALU_SLT: result = {{(WORD_SIZE-1){1'b0}}, $signed(a) < $signed(b)};
            cpu_pkg::ALU_SLL: result = a << shamt;
            cpu_pkg::ALU_SRL: result = a >> shamt;
            default:          result = {WORD_SIZE{1'b0}};
        endcase
    end

    assign zero = (result == {WORD_SIZE{1'b0}});   // Branch taken on SUB when equal

    // Opcode from the front end must carry no unknown bits
    a_op_defined: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(op)
    );

endmodule

// ==== execute/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage #(
    parameter int WORD_SIZE = 32,
    parameter int NUM_REGS  = 32,
    parameter int ADDR_SIZE = 10,
    localparam int REG_SEL  = $clog2(NUM_REGS)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [ADDR_SIZE-1:0] pc,            // PC of the issued instruction
    input  cpu_pkg::alu_op_e     alu_op,
    input  logic [REG_SEL-1:0]   rs1,
    input  logic [REG_SEL-1:0]   rs2,
    input  logic [REG_SEL-1:0]   rd,
    input  logic [WORD_SIZE-1:0] imm,
    input  logic                 use_imm,       // Operand b from imm
    input  logic                 branch,
    input  logic                 jump,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  logic                 reg_write,
    input  logic [WORD_SIZE-1:0] rs1_data,
    input  logic [WORD_SIZE-1:0] rs2_data,
    output logic [REG_SEL-1:0]   rs1_sel,       // To register file
    output logic [REG_SEL-1:0]   rs2_sel,
    ex_mem_if.producer           ex_bus
);

    logic [WORD_SIZE-1:0] op_b;

    assign rs1_sel = rs1;
    assign rs2_sel = rs2;
    assign op_b    = use_imm ? imm : rs2_data;

    alu #(
        .WORD_SIZE (WORD_SIZE)
    ) alu0 (
        .clk    (clk),
        .rst    (rst),
        .op     (alu_op),
        .a      (rs1_data),
        .b      (op_b),
        .result (ex_bus.alu_result),
        .zero   (ex_bus.alu_zero)
    );

    // Branch target from PC and truncated immediate
    assign ex_bus.branch_target = pc + imm[ADDR_SIZE-1:0];
    assign ex_bus.write_data    = rs2_data;     // Store data
    assign ex_bus.rd            = rd;

    // Control bits pass straight through
    assign ex_bus.branch    = branch;
    assign ex_bus.jump      = jump;
    assign ex_bus.mem_read  = mem_read;
    assign ex_bus.mem_write = mem_write;
    assign ex_bus.reg_write = reg_write;

endmodule

// ==== src/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg #(
    parameter int WORD_SIZE = 32,
    parameter int NUM_REGS  = 32,
    parameter int ADDR_SIZE = 10,
    localparam int REG_SEL  = $clog2(NUM_REGS)
) (
    input  logic        clk,
    input  logic        rst,
    ex_mem_if.consumer  in_bus,     // From execute
    ex_mem_if.producer  out_bus     // To memory stage
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_bus.branch_target <= {ADDR_SIZE{1'b0}};
            out_bus.alu_result    <= {WORD_SIZE{1'b0}};
            out_bus.write_data    <= {WORD_SIZE{1'b0}};
            out_bus.rd            <= {REG_SEL{1'b0}};
            out_bus.alu_zero      <= 1'b0;
            out_bus.branch        <= 1'b0;     // Reset state is a bubble
            out_bus.jump          <= 1'b0;
            out_bus.mem_read      <= 1'b0;
            out_bus.mem_write     <= 1'b0;
            out_bus.reg_write     <= 1'b0;
        end else begin
            out_bus.branch_target <= in_bus.branch_target;
            out_bus.alu_result    <= in_bus.alu_result;
            out_bus.write_data    <= in_bus.write_data;
            out_bus.rd            <= in_bus.rd;
            out_bus.alu_zero      <= in_bus.alu_zero;
            out_bus.branch        <= in_bus.branch;
            out_bus.jump          <= in_bus.jump;
            out_bus.mem_read      <= in_bus.mem_read;
            out_bus.mem_write     <= in_bus.mem_write;
            out_bus.reg_write     <= in_bus.reg_write;
        end
    end

    // One memory access per instruction
    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (rst) !(out_bus.mem_read && out_bus.mem_write));

    // Branch and jump are distinct instruction classes
    a_br_jmp_excl: assert property (
        @(posedge clk) disable iff (rst) !(out_bus.branch && out_bus.jump));

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
    parameter int WORD_SIZE = 32,
    parameter int NUM_REGS  = 32,
    localparam int REG_SEL  = $clog2(NUM_REGS)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [REG_SEL-1:0]   rs1_sel,
    input  logic [REG_SEL-1:0]   rs2_sel,
    output logic [WORD_SIZE-1:0] rs1_data,
    output logic [WORD_SIZE-1:0] rs2_data,
    input  logic                 wb_en,      // Write port from write-back
    input  logic [REG_SEL-1:0]   wb_rd,
    input  logic [WORD_SIZE-1:0] wb_data
);

    logic [WORD_SIZE-1:0] regs [NUM_REGS];

    // Register 0 never written
    always_ff @(posedge clk) begin
        if (wb_en && (wb_rd != {REG_SEL{1'b0}}))
            regs[wb_rd] <= wb_data;
    end

    // Zero register first, then write-through, then array
    assign rs1_data = (rs1_sel == {REG_SEL{1'b0}})   ? {WORD_SIZE{1'b0}} :
                      (wb_en && (wb_rd == rs1_sel)) ? wb_data : regs[rs1_sel];
    assign rs2_data = (rs2_sel == {REG_SEL{1'b0}})   ? {WORD_SIZE{1'b0}} :
                      (wb_en && (wb_rd == rs2_sel)) ? wb_data : regs[rs2_sel];

    // Register 0 reads zero even right after a write to it
    a_zero_reg: assert property (
        @(posedge clk) disable iff (rst)
        ((rs1_sel == {REG_SEL{1'b0}}) |-> (rs1_data == {WORD_SIZE{1'b0}})) and
        ((rs2_sel == {REG_SEL{1'b0}}) |-> (rs2_data == {WORD_SIZE{1'b0}})));

endmodule

// ==== memory/data_mem.sv ====
`timescale 1ns/1ps

module data_mem #(
    parameter int WORD_SIZE = 32,
    parameter int ADDR_SIZE = 10
) (
    input  logic                 clk,
    input  logic                 we,         // Store enable
    input  logic [ADDR_SIZE-1:0] addr,       // Word address
    input  logic [WORD_SIZE-1:0] wdata,
    output logic [WORD_SIZE-1:0] rdata
);

    localparam int DEPTH = 2 ** ADDR_SIZE;

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    logic [WORD_SIZE-1:0] mem [DEPTH];

    // Write lands on the clock edge
    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
    end

    // Read is asynchronous, same-cycle as the address
    assign rdata = mem[addr];

endmodule

// ==== memory/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage #(
    parameter int WORD_SIZE = 32,
    parameter int NUM_REGS  = 32,
    parameter int ADDR_SIZE = 10,
    localparam int REG_SEL  = $clog2(NUM_REGS)
) (
    input  logic                 clk,
    input  logic                 rst,
    ex_mem_if.consumer           mem_bus,
    output logic                 redirect,      // Front end takes redirect_pc
    output logic [ADDR_SIZE-1:0] redirect_pc,
    output logic                 wb_en,
    output logic [REG_SEL-1:0]   wb_rd,
    output logic [WORD_SIZE-1:0] wb_data
);

    logic [WORD_SIZE-1:0] load_data;

    //////////////////////////////////////////////////////////////////////
    // Branch and jump resolution
    //////////////////////////////////////////////////////////////////////

    assign redirect    = mem_bus.jump || (mem_bus.branch && mem_bus.alu_zero);
    assign redirect_pc = mem_bus.branch_target;

    // Word address from low bits of the ALU result
    data_mem #(
        .WORD_SIZE (WORD_SIZE),
        .ADDR_SIZE (ADDR_SIZE)
    ) dmem0 (
        .clk   (clk),
        .we    (mem_bus.mem_write),
        .addr  (mem_bus.alu_result[ADDR_SIZE-1:0]),
        .wdata (mem_bus.write_data),
        .rdata (load_data)
    );

    //////////////////////////////////////////////////////////////////////
    // MEM/WB register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_en   <= 1'b0;
            wb_rd   <= {REG_SEL{1'b0}};
            wb_data <= {WORD_SIZE{1'b0}};
        end else begin
            wb_en   <= mem_bus.reg_write;
            wb_rd   <= mem_bus.rd;
            wb_data <= mem_bus.mem_read ? load_data : mem_bus.alu_result;  // Load or ALU
        end
    end

endmodule

// ==== src/backend_top.sv ====
`timescale 1ns/1ps

module backend_top #(
    parameter int WORD_SIZE = 32,
    parameter int NUM_REGS  = 32,
    parameter int ADDR_SIZE = 10,
    localparam int REG_SEL  = $clog2(NUM_REGS)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [ADDR_SIZE-1:0] pc,            // Decoded fields from the front end
    input  cpu_pkg::alu_op_e     alu_op,
    input  logic [REG_SEL-1:0]   rs1,
    input  logic [REG_SEL-1:0]   rs2,
    input  logic [REG_SEL-1:0]   rd,
    input  logic [WORD_SIZE-1:0] imm,
    input  logic                 use_imm,
    input  logic                 branch,
    input  logic                 jump,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  logic                 reg_write,
    output logic                 redirect,      // One cycle after issue
    output logic [ADDR_SIZE-1:0] redirect_pc,
    output logic                 wb_en,         // Two cycles after issue
    output logic [REG_SEL-1:0]   wb_rd,
    output logic [WORD_SIZE-1:0] wb_data
);

    logic [REG_SEL-1:0]   rs1_sel;
    logic [REG_SEL-1:0]   rs2_sel;
    logic [WORD_SIZE-1:0] rs1_data;
    logic [WORD_SIZE-1:0] rs2_data;

    ex_mem_if #(.WORD_SIZE(WORD_SIZE), .REG_SEL(REG_SEL), .ADDR_SIZE(ADDR_SIZE)) ex_bus ();
    ex_mem_if #(.WORD_SIZE(WORD_SIZE), .REG_SEL(REG_SEL), .ADDR_SIZE(ADDR_SIZE)) mem_bus ();

    reg_file #(.WORD_SIZE(WORD_SIZE), .NUM_REGS(NUM_REGS)) rf0 (
        .clk(clk), .rst(rst), .rs1_sel(rs1_sel), .rs2_sel(rs2_sel),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)      // Write-back loop
    );

    execute_stage #(.WORD_SIZE(WORD_SIZE), .NUM_REGS(NUM_REGS), .ADDR_SIZE(ADDR_SIZE)) ex0 (
        .clk(clk), .rst(rst), .pc(pc), .alu_op(alu_op), .rs1(rs1), .rs2(rs2), .rd(rd),
        .imm(imm), .use_imm(use_imm), .branch(branch), .jump(jump),
        .mem_read(mem_read), .mem_write(mem_write), .reg_write(reg_write),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_sel(rs1_sel), .rs2_sel(rs2_sel), .ex_bus(ex_bus.producer)
    );

    ex_mem_reg #(.WORD_SIZE(WORD_SIZE), .NUM_REGS(NUM_REGS), .ADDR_SIZE(ADDR_SIZE)) exm0 (
        .clk(clk), .rst(rst), .in_bus(ex_bus.consumer), .out_bus(mem_bus.producer)
    );

    mem_stage #(.WORD_SIZE(WORD_SIZE), .NUM_REGS(NUM_REGS), .ADDR_SIZE(ADDR_SIZE)) mem0 (
        .clk(clk), .rst(rst), .mem_bus(mem_bus.consumer),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
    );

endmodule

// ==== dv/backend_tb.sv ====
`timescale 1ns/1ps

module backend_tb;

    localparam int MAX_ENTRIES  = 64;
    localparam int RESET_CYCLES = 2;

    // Control bits {branch, jump, mem_read, mem_write, reg_write}
    localparam logic [4:0] CTL_NONE = 5'b00000;
    localparam logic [4:0] CTL_ALU  = 5'b00001;
    localparam logic [4:0] CTL_ST   = 5'b00010;
    localparam logic [4:0] CTL_LD   = 5'b00101;
    localparam logic [4:0] CTL_JMP  = 5'b01000;
    localparam logic [4:0] CTL_BR   = 5'b10000;

    typedef struct packed {
        logic [9:0]       pc;
        cpu_pkg::alu_op_e op;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
        logic [31:0]      imm;
        logic             use_imm;
        logic             branch;
        logic             jump;
        logic             mem_read;
        logic             mem_write;
        logic             reg_write;
    } instr_t;

    logic clk, rst, use_imm, branch, jump, mem_read, mem_write, reg_write;
    logic [9:0] pc;
    cpu_pkg::alu_op_e alu_op;
    logic [4:0] rs1, rs2, rd, wb_rd;
    logic [31:0] imm, wb_data;
    logic redirect, wb_en;
    logic [9:0] redirect_pc;

    instr_t      stim [MAX_ENTRIES];     // Stimulus table
    int          num_entries;
    logic [31:0] rand_state;
    int          cycle_count;
    int          timeout_cycles;

    // Reference model state and per-entry expectations
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [1024];
    logic [31:0] exp_alu [MAX_ENTRIES];
    logic [31:0] exp_store [MAX_ENTRIES];   // rs2 value at issue
    logic [31:0] exp_wb_data [MAX_ENTRIES];
    bit          exp_redir [MAX_ENTRIES];
    logic [9:0]  exp_pc [MAX_ENTRIES];

    backend_top dut0 (
        .clk(clk), .rst(rst), .pc(pc), .alu_op(alu_op), .rs1(rs1), .rs2(rs2), .rd(rd),
        .imm(imm), .use_imm(use_imm), .branch(branch), .jump(jump), .mem_read(mem_read),
        .mem_write(mem_write), .reg_write(reg_write), .redirect(redirect),
        .redirect_pc(redirect_pc), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    always #20 clk = ~clk;  // 40 ns period

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (timeout_cycles > 0 && cycle_count > timeout_cycles) begin
            $display("Timeout: pipeline run did not finish within %0d cycles", timeout_cycles);
            $display("Finished with errors");
            $fatal(1, "Run stopped by cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;   // LCG step
        return rand_state;
    endfunction

    // Golden ALU from the opcode definitions
    function automatic logic [31:0] ref_alu(input cpu_pkg::alu_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] res;
        case (op)
            cpu_pkg::ALU_ADD: res = a + b;
            cpu_pkg::ALU_SUB: res = a - b;
            cpu_pkg::ALU_AND: res = a & b;
            cpu_pkg::ALU_OR:  res = a | b;
            cpu_pkg::ALU_XOR: res = a ^ b;
            cpu_pkg::ALU_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            cpu_pkg::ALU_SLL: res = a << b[4:0];
            default:          res = a >> b[4:0];    // SRL
        endcase
        return res;
    endfunction

    task automatic add_entry(input cpu_pkg::alu_op_e op, input int rd_i, input int rs1_i,
                             input int rs2_i, input logic [31:0] imm_i, input logic use_imm_i,
                             input logic [4:0] ctrl, input logic [9:0] pc_i);
        stim[num_entries] = '{pc_i, op, rs1_i[4:0], rs2_i[4:0], rd_i[4:0], imm_i, use_imm_i,
                              ctrl[4], ctrl[3], ctrl[2], ctrl[1], ctrl[0]};
        num_entries = num_entries + 1;
    endtask

    task automatic build_program();
        // Operand loads with r1 positive and r3 negative for signed compare
        add_entry(cpu_pkg::ALU_ADD, 1, 0, 0, next_random() & 32'h7fff_ffff, 1, CTL_ALU, 0);
        add_entry(cpu_pkg::ALU_ADD, 2, 0, 0, next_random(), 1, CTL_ALU, 0);
        add_entry(cpu_pkg::ALU_ADD, 3, 0, 0, next_random() | 32'h8000_0000, 1, CTL_ALU, 0);
        add_entry(cpu_pkg::ALU_ADD, 4, 0, 0, next_random(), 1, CTL_ALU, 0);
        add_entry(cpu_pkg::ALU_ADD, 0, 0, 0, 0, 0, CTL_NONE, 0);
        // Every op back to back on registers then on immediates
        for (int i = 0; i < 8; i++)
            add_entry(cpu_pkg::alu_op_e'(i), 5 + i, 3, 1, 0, 0, CTL_ALU, 0);
        for (int i = 0; i < 8; i++)
            add_entry(cpu_pkg::alu_op_e'(i), 13 + i, 1, 0, next_random() | 32'h8000_0000, 1,
                      CTL_ALU, 0);
        // Store then load of the same word twice
        add_entry(cpu_pkg::ALU_ADD, 0, 4, 1, 8, 1, CTL_ST, 0);
        add_entry(cpu_pkg::ALU_ADD, 21, 4, 0, 8, 1, CTL_LD, 0);
        add_entry(cpu_pkg::ALU_ADD, 0, 0, 2, 100, 1, CTL_ST, 0);
        add_entry(cpu_pkg::ALU_ADD, 22, 0, 0, 100, 1, CTL_LD, 0);
        add_entry(cpu_pkg::ALU_ADD, 0, 0, 0, 0, 0, CTL_NONE, 0);
        add_entry(cpu_pkg::ALU_SUB, 0, 5, 5, 32'h20, 0, CTL_BR, 10'h040);    // Taken
        add_entry(cpu_pkg::ALU_SUB, 0, 1, 2, 32'h10, 0, CTL_BR, 10'h044);    // Not taken
        add_entry(cpu_pkg::ALU_ADD, 0, 0, 0, 32'h3f0, 1, CTL_JMP, 10'h048);  // Target wraps
        add_entry(cpu_pkg::ALU_ADD, 0, 0, 0, 32'h55, 1, CTL_ALU, 0);         // Write to r0
        add_entry(cpu_pkg::ALU_ADD, 0, 0, 0, 0, 0, CTL_NONE, 0);
        add_entry(cpu_pkg::ALU_ADD, 23, 0, 1, 0, 0, CTL_ALU, 0);
        add_entry(cpu_pkg::ALU_ADD, 24, 21, 22, 0, 0, CTL_ALU, 0);
        add_entry(cpu_pkg::ALU_ADD, 0, 0, 0, 0, 0, CTL_NONE, 0);              // Drain
        add_entry(cpu_pkg::ALU_ADD, 0, 0, 0, 0, 0, CTL_NONE, 0);
    endtask

    task automatic drive_entry(input instr_t e);
        pc        = e.pc;
        alu_op    = e.op;
        rs1       = e.rs1;
        rs2       = e.rs2;
        rd        = e.rd;
        imm       = e.imm;
        use_imm   = e.use_imm;
        branch    = e.branch;
        jump      = e.jump;
        mem_read  = e.mem_read;
        mem_write = e.mem_write;
        reg_write = e.reg_write;
    endtask

    initial begin
        instr_t e;
        instr_t p;
        int k;
        clk = 1'b0;
        rst = 1'b1;
        rand_state = 32'd89;
        num_entries = 0;
        cycle_count = 0;
        timeout_cycles = 0;
        drive_entry('0);
        for (k = 0; k < 32; k++)
            model_regs[k] = 32'd0;
        build_program();
        timeout_cycles = num_entries + RESET_CYCLES + 10;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("redirect", redirect, 0);
            check_value("wb_en", wb_en, 0);
        end
        rst = 1'b0;

        //////////////////////////////////////////////////////////////////////
        // One entry per cycle with model stages in hardware order
        //////////////////////////////////////////////////////////////////////
        for (k = 0; k < num_entries; k++) begin
            e = stim[k];
            if (k >= 2 && stim[k-2].reg_write) begin    // Write-back of k-2
                check_value("wb_en", wb_en, 1);
                check_value("wb_rd", wb_rd, stim[k-2].rd);
                check_value("wb_data", wb_data, exp_wb_data[k-2]);
                if (stim[k-2].rd != 5'd0)
                    model_regs[stim[k-2].rd] = exp_wb_data[k-2];
            end else begin
                check_value("wb_en", wb_en, 0);
            end
            if (k >= 1) begin   // Memory stage of k-1
                p = stim[k-1];
                exp_wb_data[k-1] = p.mem_read ? model_mem[exp_alu[k-1][9:0]] : exp_alu[k-1];
                if (p.mem_write)
                    model_mem[exp_alu[k-1][9:0]] = exp_store[k-1];
                check_value("redirect", redirect, exp_redir[k-1]);
                if (exp_redir[k-1])
                    check_value("redirect_pc", redirect_pc, exp_pc[k-1]);
            end else begin
                check_value("redirect", redirect, 0);
            end
            // Execute of k with register 0 held at zero in the model
            exp_store[k] = model_regs[e.rs2];
            exp_alu[k]   = ref_alu(e.op, model_regs[e.rs1], e.use_imm ? e.imm : exp_store[k]);
            exp_redir[k] = e.jump || (e.branch && exp_alu[k] == 32'd0);
            exp_pc[k]    = e.pc + e.imm[9:0];
            drive_entry(e);
            @(negedge clk);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== filelist.f ====
common/cpu_pkg.sv
common/ex_mem_if.sv
execute/alu.sv
execute/execute_stage.sv
src/ex_mem_reg.sv
src/reg_file.sv
memory/data_mem.sv
memory/mem_stage.sv
src/backend_top.sv
dv/backend_tb.sv

// ==== Bender.yml ====
package:
  name: backend

sources:
  - common/cpu_pkg.sv
  - common/ex_mem_if.sv
  - execute/alu.sv
  - execute/execute_stage.sv
  - src/ex_mem_reg.sv
  - src/reg_file.sv
  - memory/data_mem.sv
  - memory/mem_stage.sv
  - src/backend_top.sv
  - target: simulation
    files:
      - dv/backend_tb.sv
